// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_epu
FILELIST = tb.f
OBJ_DIR  = obj_dir
LOG      = sim.log
FAIL_MSG = Test failures found
PASS_MSG = All tests passed!

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation did not complete"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bench/epu_assert.sv ====
`timescale 1ns/1ns
`default_nettype none

module epu_assert (
    input logic clk,
    input logic rst,
    input logic awready_i,
    input logic wready_i,
    input logic bvalid_i,
    input logic bready_i,
    input logic rvalid_i,
    input logic rready_i,
    input logic rlast_i
);

    // A response offered to the master stays up until taken
    bvalid_hold: assert property (@(posedge clk) disable iff (!rst)
        bvalid_i && !bready_i |=> bvalid_i)
        else $error("bvalid_o dropped before its handshake");

    rvalid_hold: assert property (@(posedge clk) disable iff (!rst)
        rvalid_i && !rready_i |=> rvalid_i)
        else $error("rvalid_o dropped before its handshake");

    rlast_valid: assert property (@(posedge clk) disable iff (!rst)
        rlast_i |-> rvalid_i)
        else $error("rlast_o high without rvalid_o");

    // Address and data phases never overlap
    aw_w_exclusive: assert property (@(posedge clk) disable iff (!rst)
        !(awready_i && wready_i))
        else $error("awready_o and wready_o high together");

endmodule

bind slave_fsm epu_assert epu_assert_inst (
    .clk       (clk),
    .rst       (rst),
    .awready_i (awready_o),
    .wready_i  (wready_o),
    .bvalid_i  (bvalid_o),
    .bready_i  (bready_i),
    .rvalid_i  (rvalid_o),
    .rready_i  (rready_i),
    .rlast_i   (rlast_o)
);

`default_nettype wire

// ==== bench/tb_epu.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_epu;
    import bus_pkg::*;
    import epu_pkg::*;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 16;
    localparam int NUM_TESTS    = 8;
    localparam logic [31:0] UNMAPPED_BASE = 32'h6000_0000;

    typedef struct packed {
        region_e     region;
        logic [7:0]  start;
        logic [7:0]  len;
        logic [31:0] dseed;
        logic        stall;
    } test_t;

    // Region, start index, length (LEN for CTRL runs), data seed, rready stalls
    test_t tests [NUM_TESTS] = '{
        '{ACT,  8'd0,  8'd64, 32'h0000_1111, 1'b0},
        '{WGT,  8'd0,  8'd64, 32'h0000_2222, 1'b0},
        '{ACT,  8'd5,  8'd12, 32'h0003_3330, 1'b1},
        '{WGT,  8'd60, 8'd8,  32'h0000_4444, 1'b1},
        '{NONE, 8'd3,  8'd4,  32'h0000_5555, 1'b0},
        '{CTRL, 8'd0,  8'd16, 32'h0000_0000, 1'b0},
        '{ACT,  8'd0,  8'd1,  32'h0006_6660, 1'b0},
        '{CTRL, 8'd0,  8'd64, 32'h0000_0000, 1'b1}
    };

    logic                 clk;
    logic                 rst;
    logic                 awvalid_i;
    logic                 awready_o;
    logic [ADDR_BITS-1:0] awaddr_i;
    logic [LEN_BITS-1:0]  awlen_i;
    logic [ID_BITS-1:0]   awid_i;
    logic                 wvalid_i;
    logic                 wready_o;
    logic [DATA_BITS-1:0] wdata_i;
    logic                 wlast_i;
    logic                 bvalid_o;
    logic                 bready_i;
    logic [RESP_BITS-1:0] bresp_o;
    logic [ID_BITS-1:0]   bid_o;
    logic                 arvalid_i;
    logic                 arready_o;
    logic [ADDR_BITS-1:0] araddr_i;
    logic [LEN_BITS-1:0]  arlen_i;
    logic [ID_BITS-1:0]   arid_i;
    logic                 rvalid_o;
    logic                 rready_i;
    logic [DATA_BITS-1:0] rdata_o;
    logic [RESP_BITS-1:0] rresp_o;
    logic                 rlast_o;
    logic [ID_BITS-1:0]   rid_o;
    logic                 done_o;

    // Reference copy of both buffers
    act_t act_m [BUF_DEPTH];
    wgt_t wgt_m [BUF_DEPTH];

    logic [DATA_BITS-1:0] wbuf    [BUF_DEPTH];
    logic [DATA_BITS-1:0] rd_data [BUF_DEPTH];
    logic                 rd_last [BUF_DEPTH];
    logic [RESP_BITS-1:0] rd_resp [BUF_DEPTH];
    logic [ID_BITS-1:0]   rd_id   [BUF_DEPTH];

    int seed;
    int err_count;
    int check_count;

    epu_top epu_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("FAIL %s: got 0x%08h, expected 0x%08h", name, got, exp);
        end
    endtask

    task automatic burst_write(input logic [31:0] addr, input int n, input logic [3:0] id,
                               output logic [1:0] resp, output logic [3:0] bid);
        int b;
        @(negedge clk);
        awvalid_i = 1'b1;
        awaddr_i  = addr;
        awlen_i   = 8'(n - 1);
        awid_i    = id;
        while (!awready_o) @(negedge clk);
        @(negedge clk);
        awvalid_i = 1'b0;
        for (b = 0; b < n; b++) begin
            wvalid_i = 1'b1;
            wdata_i  = wbuf[b];
            wlast_i  = (b == n - 1);
            while (!wready_o) @(negedge clk);
            @(negedge clk);
        end
        wvalid_i = 1'b0;
        wlast_i  = 1'b0;
        while (!bvalid_o) @(negedge clk);
        // Leave the response waiting one cycle before accepting it
        @(negedge clk);
        bready_i = 1'b1;
        resp = bresp_o;
        bid  = bid_o;
        @(negedge clk);
        bready_i = 1'b0;
    endtask

    // Beats are captured at the negedge before the handshake edge
    task automatic burst_read(input logic [31:0] addr, input int n, input logic [3:0] id,
                              input logic stall);
        int b;
        int r;
        @(negedge clk);
        arvalid_i = 1'b1;
        araddr_i  = addr;
        arlen_i   = 8'(n - 1);
        arid_i    = id;
        while (!arready_o) @(negedge clk);
        @(negedge clk);
        arvalid_i = 1'b0;
        b = 0;
        while (b < n) begin
            r = $random(seed);
            rready_i = stall ? r[0] : 1'b1;
            if (rvalid_o && rready_i) begin
                rd_data[b] = rdata_o;
                rd_last[b] = rlast_o;
                rd_resp[b] = rresp_o;
                rd_id[b]   = rid_o;
                b++;
            end
            @(negedge clk);
        end
        rready_i = 1'b0;
    endtask

    task automatic read_and_compare(input region_e region, input int start, input int n,
                                    input logic [3:0] id, input logic stall);
        logic [31:0] base;
        logic [31:0] exp;
        int          i;
        int          idx;
        base = (region == ACT) ? ACT_BASE : WGT_BASE;
        burst_read(base + 32'(start), n, id, stall);
        for (i = 0; i < n; i++) begin
            idx = (start + i) % BUF_DEPTH;
            if (region == ACT) begin
                exp = {16'h0000, act_m[idx]};
            end else begin
                exp = {{24{wgt_m[idx][7]}}, wgt_m[idx]};
            end
            check("rdata_o", rd_data[i], exp);
            check("rresp_o", 32'(rd_resp[i]), 32'(RESP_OKAY));
            check("rlast_o", 32'(rd_last[i]), 32'(i == n - 1));
            check("rid_o", 32'(rd_id[i]), 32'(id));
        end
    endtask

    task automatic buffer_test(input int t);
        logic [31:0] base;
        logic [3:0]  id;
        logic [1:0]  resp;
        logic [3:0]  bid;
        int          s;
        int          n;
        int          i;
        int          idx;
        s    = int'(tests[t].start);
        n    = int'(tests[t].len);
        id   = 4'(t);
        base = (tests[t].region == ACT) ? ACT_BASE : WGT_BASE;
        for (i = 0; i < n; i++) begin
            wbuf[i] = $random(seed) ^ tests[t].dseed;
        end
        burst_write(base + 32'(s), n, id, resp, bid);
        check("bresp_o", 32'(resp), 32'(RESP_OKAY));
        check("bid_o", 32'(bid), 32'(id));
        for (i = 0; i < n; i++) begin
            idx = (s + i) % BUF_DEPTH;
            if (tests[t].region == ACT) begin
                act_m[idx] = wbuf[i][15:0];
            end else begin
                wgt_m[idx] = wbuf[i][7:0];
            end
        end
        read_and_compare(tests[t].region, s, n, id ^ 4'hF, tests[t].stall);
    endtask

    task automatic unmapped_test(input int t);
        logic [3:0] id;
        logic [1:0] resp;
        logic [3:0] bid;
        int         s;
        int         n;
        int         i;
        s  = int'(tests[t].start);
        n  = int'(tests[t].len);
        id = 4'(t);
        for (i = 0; i < n; i++) begin
            wbuf[i] = $random(seed) ^ tests[t].dseed;
        end
        burst_write(UNMAPPED_BASE + 32'(s), n, id, resp, bid);
        check("bresp_o", 32'(resp), 32'(RESP_SLVERR));
        check("bid_o", 32'(bid), 32'(id));
        burst_read(UNMAPPED_BASE + 32'(s), n, id, tests[t].stall);
        for (i = 0; i < n; i++) begin
            check("rdata_o", rd_data[i], 32'h0);
            check("rresp_o", 32'(rd_resp[i]), 32'(RESP_SLVERR));
            check("rlast_o", 32'(rd_last[i]), 32'(i == n - 1));
        end
        // Neither buffer may have picked up the dropped writes
        read_and_compare(ACT, s, n, id ^ 4'hA, 1'b0);
        read_and_compare(WGT, s, n, id ^ 4'h5, 1'b0);
    endtask

    task automatic engine_test(input int t);
        logic [3:0] id;
        logic [1:0] resp;
        logic [3:0] bid;
        int         len;
        int         sum;
        int         i;
        int         cyc;
        len = int'(tests[t].len);
        id  = 4'(t);
        sum = 0;
        for (i = 0; i < len; i++) begin
            sum += int'(act_m[i]) * int'(wgt_m[i]);
        end
        wbuf[0] = 32'(len);
        burst_write(CTRL_BASE + 32'(REG_LEN), 1, id, resp, bid);
        check("bresp_o", 32'(resp), 32'(RESP_OKAY));
        check("bid_o", 32'(bid), 32'(id));
        wbuf[0] = 32'h1;
        burst_write(CTRL_BASE + 32'(REG_START), 1, id ^ 4'h3, resp, bid);
        check("bresp_o", 32'(resp), 32'(RESP_OKAY));
        check("bid_o", 32'(bid), 32'(id ^ 4'h3));
        cyc = 0;
        while (!done_o && cyc < len + 10) begin
            @(negedge clk);
            cyc++;
        end
        if (!done_o) begin
            err_count++;
            $display("ERROR done_o did not rise within %0d cycles of START", len + 10);
        end
        burst_read(CTRL_BASE + 32'(REG_STATUS), 1, id, tests[t].stall);
        check("status", rd_data[0], 32'h1);
        burst_read(CTRL_BASE + 32'(REG_RESULT), 1, id, tests[t].stall);
        check("result", rd_data[0], 32'(sum));
        check("rresp_o", 32'(rd_resp[0]), 32'(RESP_OKAY));
    endtask

    initial begin : main
        int t;
        int errs_before;
        seed        = 64556;
        err_count   = 0;
        check_count = 0;
        rst       = 1'b0;
        awvalid_i = 1'b0;
        awaddr_i  = '0;
        awlen_i   = '0;
        awid_i    = '0;
        wvalid_i  = 1'b0;
        wdata_i   = '0;
        wlast_i   = 1'b0;
        bready_i  = 1'b0;
        arvalid_i = 1'b0;
        araddr_i  = '0;
        arlen_i   = '0;
        arid_i    = '0;
        rready_i  = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;
        @(negedge clk);
        check("awready_o", 32'(awready_o), 32'h1);
        check("arready_o", 32'(arready_o), 32'h1);
        check("wready_o", 32'(wready_o), 32'h0);
        check("bvalid_o", 32'(bvalid_o), 32'h0);
        check("rvalid_o", 32'(rvalid_o), 32'h0);
        check("done_o", 32'(done_o), 32'h0);
        for (t = 0; t < NUM_TESTS; t++) begin
            errs_before = err_count;
            case (tests[t].region)
                ACT, WGT: buffer_test(t);
                NONE:     unmapped_test(t);
                default:  engine_test(t);
            endcase
            $display("test %0d %s start %0d len %0d: %0d errors", t,
                     tests[t].region.name(), tests[t].start, tests[t].len,
                     err_count - errs_before);
        end
        $display("%0d tests, %0d checks, %0d errors", NUM_TESTS, check_count, err_count);
        if (err_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // Generous budget per table entry
    initial begin : watchdog
        repeat (NUM_TESTS * 200 + RESET_CYCLES) @(posedge clk);
        $display("Timeout: the tests did not finish within %0d cycles",
                 NUM_TESTS * 200 + RESET_CYCLES);
        $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

// ==== common/bus_pkg.sv ====
`default_nettype none

package bus_pkg;

    // Slave port widths
    localparam int ADDR_BITS = 32;
    localparam int DATA_BITS = 32;
    localparam int ID_BITS   = 4;

    // Burst length field carries beats minus one
    localparam int LEN_BITS  = 8;

    // Response codes
    localparam int RESP_BITS = 2;
    localparam logic [RESP_BITS-1:0] RESP_OKAY   = 2'd0;
    localparam logic [RESP_BITS-1:0] RESP_SLVERR = 2'd2;

endpackage

`default_nettype wire

// ==== common/epu_pkg.sv ====
`default_nettype none

package epu_pkg;

    // Both buffers hold the same number of elements
    localparam int BUF_DEPTH = 64;
    localparam int IDX_BITS  = $clog2(BUF_DEPTH);

    // Element and accumulator formats
    typedef logic        [15:0] act_t;
    typedef logic signed [7:0]  wgt_t;
    typedef logic signed [31:0] acc_t;

    typedef enum logic [1:0] {
        NONE,
        ACT,
        WGT,
        CTRL
    } region_e;

    // Regions match on the address bits from TAG_LSB upward
    localparam int TAG_LSB = 16;
    localparam logic [31:0] ACT_BASE  = 32'h5000_0000;
    localparam logic [31:0] WGT_BASE  = 32'h7000_0000;
    localparam logic [31:0] CTRL_BASE = 32'h8000_0000;

    // Control register byte offsets
    localparam int REG_OFF_BITS = 4;
    localparam logic [REG_OFF_BITS-1:0] REG_LEN    = 4'h0;
    localparam logic [REG_OFF_BITS-1:0] REG_START  = 4'h4;
    localparam logic [REG_OFF_BITS-1:0] REG_STATUS = 4'h8;
    localparam logic [REG_OFF_BITS-1:0] REG_RESULT = 4'hC;

endpackage

`default_nettype wire

// ==== dot_engine/dot_engine.sv ====
`timescale 1ns/1ns
`default_nettype none

module dot_engine (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         start_i,
    input  logic [epu_pkg::IDX_BITS:0]   len_i,
    input  epu_pkg::act_t                act_rdata_i,
    input  epu_pkg::wgt_t                wgt_rdata_i,
    output logic [epu_pkg::IDX_BITS-1:0] raddr_o,
    output logic                         busy_o,
    output logic                         done_o,
    output epu_pkg::acc_t                result_o
);
    import epu_pkg::*;

    logic [IDX_BITS-1:0] last_idx;
    logic                idx_last;
    logic                run_q;
    logic                rd_v_q;
    logic                rd_last_q;
    logic                mul_v_q;
    logic                mul_last_q;
    logic                sum_last_q;
    acc_t                prod_q;
    acc_t                acc_q;

    // LEN of 0 wraps to a full buffer
    assign last_idx = IDX_BITS'(len_i - 1'b1);

    burst_counter #(
        .W(IDX_BITS)
    ) elem_cnt_inst (
        .clk        (clk),
        .rst        (rst),
        .load_i     (start_i),
        .step_i     (run_q),
        .len_i      (last_idx),
        .idx_o      (raddr_o),
        .next_idx_o (),
        .last_o     (idx_last)
    );

    // Issue, read, multiply and add stages each carry a valid and a last flag
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            run_q      <= 1'b0;
            rd_v_q     <= 1'b0;
            rd_last_q  <= 1'b0;
            mul_v_q    <= 1'b0;
            mul_last_q <= 1'b0;
            sum_last_q <= 1'b0;
            busy_o     <= 1'b0;
            done_o     <= 1'b0;
            result_o   <= '0;
        end else begin
            if (start_i) begin
                run_q <= 1'b1;
            end else if (run_q && idx_last) begin
                run_q <= 1'b0;
            end
            rd_v_q     <= run_q;
            rd_last_q  <= run_q && idx_last;
            mul_v_q    <= rd_v_q;
            mul_last_q <= rd_last_q;
            sum_last_q <= mul_last_q;
            if (start_i) begin
                busy_o <= 1'b1;
                done_o <= 1'b0;
            end else if (sum_last_q) begin
                busy_o   <= 1'b0;
                done_o   <= 1'b1;
                result_o <= acc_q;
            end
        end
    end

    // Activation is unsigned, widen with a zero before the signed multiply
    always_ff @(posedge clk) begin
        prod_q <= acc_t'($signed({1'b0, act_rdata_i}) * wgt_rdata_i);
        if (start_i) begin
            acc_q <= '0;
        end else if (mul_v_q) begin
            acc_q <= acc_q + prod_q;
        end
    end

endmodule

`default_nettype wire

// ==== source/buffer_ram.sv ====
`timescale 1ns/1ns
`default_nettype none

module buffer_ram #(
    parameter type elem_t = logic [7:0]
) (
    input  logic                         clk,
    input  logic                         we_i,
    input  logic [epu_pkg::IDX_BITS-1:0] waddr_i,
    input  elem_t                        wdata_i,
    input  logic [epu_pkg::IDX_BITS-1:0] raddr_i,
    output elem_t                        rdata_o,
    input  logic [epu_pkg::IDX_BITS-1:0] eng_raddr_i,
    output elem_t                        eng_rdata_o
);
    import epu_pkg::*;

    elem_t mem [BUF_DEPTH];

    // Bus side, one write port and one registered read port
    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[waddr_i] <= wdata_i;
        end
        rdata_o <= mem[raddr_i];
    end

    // Engine side read
    always_ff @(posedge clk) begin
        eng_rdata_o <= mem[eng_raddr_i];
    end

endmodule

`default_nettype wire

// ==== source/burst_counter.sv ====
`timescale 1ns/1ns
`default_nettype none

module burst_counter #(
    parameter int W = 8
) (
    input  logic         clk,
    input  logic         rst,
    input  logic         load_i,
    input  logic         step_i,
    input  logic [W-1:0] len_i,
    output logic [W-1:0] idx_o,
    output logic [W-1:0] next_idx_o,
    output logic         last_o
);

    // Value the index takes at the coming edge
    always_comb begin
        if (load_i) begin
            next_idx_o = '0;
        end else if (step_i) begin
            next_idx_o = idx_o + 1'b1;
        end else begin
            next_idx_o = idx_o;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            idx_o <= '0;
        end else begin
            idx_o <= next_idx_o;
        end
    end

    // len_i is the index of the final beat, not a count
    assign last_o = (idx_o == len_i);

endmodule

`default_nettype wire

// ==== source/epu_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module epu_top (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          awvalid_i,
    output logic                          awready_o,
    input  logic [bus_pkg::ADDR_BITS-1:0] awaddr_i,
    input  logic [bus_pkg::LEN_BITS-1:0]  awlen_i,
    input  logic [bus_pkg::ID_BITS-1:0]   awid_i,
    input  logic                          wvalid_i,
    output logic                          wready_o,
    input  logic [bus_pkg::DATA_BITS-1:0] wdata_i,
    input  logic                          wlast_i,
    output logic                          bvalid_o,
    input  logic                          bready_i,
    output logic [bus_pkg::RESP_BITS-1:0] bresp_o,
    output logic [bus_pkg::ID_BITS-1:0]   bid_o,
    input  logic                          arvalid_i,
    output logic                          arready_o,
    input  logic [bus_pkg::ADDR_BITS-1:0] araddr_i,
    input  logic [bus_pkg::LEN_BITS-1:0]  arlen_i,
    input  logic [bus_pkg::ID_BITS-1:0]   arid_i,
    output logic                          rvalid_o,
    input  logic                          rready_i,
    output logic [bus_pkg::DATA_BITS-1:0] rdata_o,
    output logic [bus_pkg::RESP_BITS-1:0] rresp_o,
    output logic                          rlast_o,
    output logic [bus_pkg::ID_BITS-1:0]   rid_o,
    output logic                          done_o
);
    import bus_pkg::*;
    import epu_pkg::*;

    logic                 beat_load;
    logic                 beat_step;
    logic                 beat_last;
    logic [LEN_BITS-1:0]  beat_idx;
    logic [LEN_BITS-1:0]  beat_next;
    logic [LEN_BITS-1:0]  burst_len;
    logic [ADDR_BITS-1:0] burst_addr;
    logic                 wr_beat;
    logic [IDX_BITS-1:0]  bus_waddr;
    logic [IDX_BITS-1:0]  bus_raddr;
    logic [IDX_BITS-1:0]  eng_raddr;
    logic                 act_we;
    logic                 wgt_we;
    act_t                 act_rdata;
    act_t                 act_eng_rdata;
    wgt_t                 wgt_rdata;
    wgt_t                 wgt_eng_rdata;
    logic                 start_pulse;
    logic                 busy;
    acc_t                 result;
    logic [IDX_BITS:0]    eng_len;
    logic [RESP_BITS-1:0] resp;

    // Element index is the start offset plus the beat number
    assign bus_waddr = burst_addr[IDX_BITS-1:0] + beat_idx[IDX_BITS-1:0];
    // Reads look one beat ahead to cover the RAM latency
    assign bus_raddr = burst_addr[IDX_BITS-1:0] + beat_next[IDX_BITS-1:0];

    // Only one of the two responses is in flight at a time
    assign bresp_o = resp;
    assign rresp_o = resp;

    slave_fsm slave_fsm_inst (
        .clk          (clk),
        .rst          (rst),
        .awvalid_i    (awvalid_i),
        .awready_o    (awready_o),
        .awaddr_i     (awaddr_i),
        .awlen_i      (awlen_i),
        .awid_i       (awid_i),
        .wvalid_i     (wvalid_i),
        .wready_o     (wready_o),
        .wlast_i      (wlast_i),
        .bvalid_o     (bvalid_o),
        .bready_i     (bready_i),
        .bid_o        (bid_o),
        .arvalid_i    (arvalid_i),
        .arready_o    (arready_o),
        .araddr_i     (araddr_i),
        .arlen_i      (arlen_i),
        .arid_i       (arid_i),
        .rvalid_o     (rvalid_o),
        .rready_i     (rready_i),
        .rlast_o      (rlast_o),
        .rid_o        (rid_o),
        .beat_load_o  (beat_load),
        .beat_step_o  (beat_step),
        .beat_last_i  (beat_last),
        .burst_addr_o (burst_addr),
        .len_o        (burst_len),
        .wr_beat_o    (wr_beat)
    );

    burst_counter #(
        .W(LEN_BITS)
    ) beat_cnt_inst (
        .clk        (clk),
        .rst        (rst),
        .load_i     (beat_load),
        .step_i     (beat_step),
        .len_i      (burst_len),
        .idx_o      (beat_idx),
        .next_idx_o (beat_next),
        .last_o     (beat_last)
    );

    buffer_ram #(
        .elem_t(act_t)
    ) act_ram_inst (
        .clk         (clk),
        .we_i        (act_we),
        .waddr_i     (bus_waddr),
        .wdata_i     (wdata_i[$bits(act_t)-1:0]),
        .raddr_i     (bus_raddr),
        .rdata_o     (act_rdata),
        .eng_raddr_i (eng_raddr),
        .eng_rdata_o (act_eng_rdata)
    );

    buffer_ram #(
        .elem_t(wgt_t)
    ) wgt_ram_inst (
        .clk         (clk),
        .we_i        (wgt_we),
        .waddr_i     (bus_waddr),
        .wdata_i     (wdata_i[$bits(wgt_t)-1:0]),
        .raddr_i     (bus_raddr),
        .rdata_o     (wgt_rdata),
        .eng_raddr_i (eng_raddr),
        .eng_rdata_o (wgt_eng_rdata)
    );

    reg_map reg_map_inst (
        .clk          (clk),
        .rst          (rst),
        .burst_addr_i (burst_addr),
        .idx_i        (beat_idx),
        .wr_beat_i    (wr_beat),
        .wdata_i      (wdata_i),
        .act_rdata_i  (act_rdata),
        .wgt_rdata_i  (wgt_rdata),
        .busy_i       (busy),
        .result_i     (result),
        .act_we_o     (act_we),
        .wgt_we_o     (wgt_we),
        .start_o      (start_pulse),
        .len_o        (eng_len),
        .rdata_o      (rdata_o),
        .resp_o       (resp)
    );

    dot_engine dot_engine_inst (
        .clk         (clk),
        .rst         (rst),
        .start_i     (start_pulse),
        .len_i       (eng_len),
        .act_rdata_i (act_eng_rdata),
        .wgt_rdata_i (wgt_eng_rdata),
        .raddr_o     (eng_raddr),
        .busy_o      (busy),
        .done_o      (done_o),
        .result_o    (result)
    );

endmodule

`default_nettype wire

// ==== source/reg_map.sv ====
`timescale 1ns/1ns
`default_nettype none

module reg_map (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [bus_pkg::ADDR_BITS-1:0] burst_addr_i,
    input  logic [bus_pkg::LEN_BITS-1:0]  idx_i,
    input  logic                          wr_beat_i,
    input  logic [bus_pkg::DATA_BITS-1:0] wdata_i,
    input  epu_pkg::act_t                 act_rdata_i,
    input  epu_pkg::wgt_t                 wgt_rdata_i,
    input  logic                          busy_i,
    input  epu_pkg::acc_t                 result_i,
    output logic                          act_we_o,
    output logic                          wgt_we_o,
    output logic                          start_o,
    output logic [epu_pkg::IDX_BITS:0]    len_o,
    output logic [bus_pkg::DATA_BITS-1:0] rdata_o,
    output logic [bus_pkg::RESP_BITS-1:0] resp_o
);
    import bus_pkg::*;
    import epu_pkg::*;

    region_e                 region;
    logic [REG_OFF_BITS-1:0] reg_off;
    logic                    ctrl_wr;
    logic                    started_q;
    logic                    done;

    always_comb begin
        if (burst_addr_i[ADDR_BITS-1:TAG_LSB] == ACT_BASE[31:TAG_LSB]) begin
            region = ACT;
        end else if (burst_addr_i[ADDR_BITS-1:TAG_LSB] == WGT_BASE[31:TAG_LSB]) begin
            region = WGT;
        end else if (burst_addr_i[ADDR_BITS-1:TAG_LSB] == CTRL_BASE[31:TAG_LSB]) begin
            region = CTRL;
        end else begin
            region = NONE;
        end
    end

    // Registers are word spaced, a burst walks them four bytes per beat
    assign reg_off = burst_addr_i[REG_OFF_BITS-1:0] + {idx_i[1:0], 2'b00};

    // Unmapped writes match no enable and are lost
    assign act_we_o = wr_beat_i && (region == ACT);
    assign wgt_we_o = wr_beat_i && (region == WGT);
    assign ctrl_wr  = wr_beat_i && (region == CTRL);
    assign start_o  = ctrl_wr && (reg_off == REG_START) && wdata_i[0];

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            len_o     <= '0;
            started_q <= 1'b0;
        end else begin
            if (ctrl_wr && (reg_off == REG_LEN)) begin
                len_o <= wdata_i[IDX_BITS:0];
            end
            if (start_o) begin
                started_q <= 1'b1;
            end
        end
    end

    // Done level follows the engine, busy drops on the edge done rises
    assign done = started_q && !busy_i;

    always_comb begin
        rdata_o = '0;
        resp_o  = RESP_OKAY;
        case (region)
            ACT: rdata_o = {{(DATA_BITS - $bits(act_t)){1'b0}}, act_rdata_i};
            WGT: rdata_o = {{(DATA_BITS - $bits(wgt_t)){wgt_rdata_i[$bits(wgt_t)-1]}},
                            wgt_rdata_i};
            CTRL: begin
                case (reg_off)
                    REG_LEN:    rdata_o = {{(DATA_BITS - IDX_BITS - 1){1'b0}}, len_o};
                    REG_STATUS: rdata_o = {{(DATA_BITS - 2){1'b0}}, busy_i, done};
                    REG_RESULT: rdata_o = result_i;
                    default:    rdata_o = '0;
                endcase
            end
            default: resp_o = RESP_SLVERR;
        endcase
    end

endmodule

`default_nettype wire

// ==== source/slave_fsm.sv ====
`timescale 1ns/1ns
`default_nettype none

module slave_fsm (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          awvalid_i,
    output logic                          awready_o,
    input  logic [bus_pkg::ADDR_BITS-1:0] awaddr_i,
    input  logic [bus_pkg::LEN_BITS-1:0]  awlen_i,
    input  logic [bus_pkg::ID_BITS-1:0]   awid_i,
    input  logic                          wvalid_i,
    output logic                          wready_o,
    input  logic                          wlast_i,
    output logic                          bvalid_o,
    input  logic                          bready_i,
    output logic [bus_pkg::ID_BITS-1:0]   bid_o,
    input  logic                          arvalid_i,
    output logic                          arready_o,
    input  logic [bus_pkg::ADDR_BITS-1:0] araddr_i,
    input  logic [bus_pkg::LEN_BITS-1:0]  arlen_i,
    input  logic [bus_pkg::ID_BITS-1:0]   arid_i,
    output logic                          rvalid_o,
    input  logic                          rready_i,
    output logic                          rlast_o,
    output logic [bus_pkg::ID_BITS-1:0]   rid_o,
    output logic                          beat_load_o,
    output logic                          beat_step_o,
    input  logic                          beat_last_i,
    output logic [bus_pkg::ADDR_BITS-1:0] burst_addr_o,
    output logic [bus_pkg::LEN_BITS-1:0]  len_o,
    output logic                          wr_beat_o
);
    import bus_pkg::*;

    typedef enum logic [1:0] {IDLE, WDATA, BRESP, RDATA} state_e;

    state_e               state_q;
    state_e               state_d;
    logic                 aw_hs;
    logic                 ar_hs;
    logic                 w_hs;
    logic                 r_hs;
    logic                 b_hs;
    logic [ADDR_BITS-1:0] addr_q;
    logic [LEN_BITS-1:0]  len_q;
    logic [ID_BITS-1:0]   id_q;

    // Write wins when both address channels are valid
    assign awready_o = (state_q == IDLE);
    assign arready_o = (state_q == IDLE) && !awvalid_i;
    assign wready_o  = (state_q == WDATA);
    assign bvalid_o  = (state_q == BRESP);
    assign rvalid_o  = (state_q == RDATA);
    assign rlast_o   = rvalid_o && beat_last_i;

    assign aw_hs = awvalid_i && awready_o;
    assign ar_hs = arvalid_i && arready_o;
    assign w_hs  = wvalid_i && wready_o;
    assign r_hs  = rvalid_o && rready_i;
    assign b_hs  = bvalid_o && bready_i;

    assign beat_load_o = aw_hs || ar_hs;
    assign beat_step_o = w_hs || r_hs;
    assign wr_beat_o   = w_hs;

    // In IDLE the address being accepted is passed through, so the RAM
    // read for beat 0 starts at the AR handshake
    assign burst_addr_o = (state_q != IDLE) ? addr_q :
                          awvalid_i ? awaddr_i : araddr_i;
    assign len_o = len_q;
    assign bid_o = id_q;
    assign rid_o = id_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (aw_hs) begin
                    state_d = WDATA;
                end else if (ar_hs) begin
                    state_d = RDATA;
                end
            end
            WDATA: begin
                if (w_hs && wlast_i) begin
                    state_d = BRESP;
                end
            end
            BRESP: begin
                if (b_hs) begin
                    state_d = IDLE;
                end
            end
            RDATA: begin
                if (r_hs && rlast_o) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state_q <= IDLE;
            addr_q  <= '0;
            len_q   <= '0;
            id_q    <= '0;
        end else begin
            state_q <= state_d;
            if (aw_hs) begin
                addr_q <= awaddr_i;
                len_q  <= awlen_i;
                id_q   <= awid_i;
            end else if (ar_hs) begin
                addr_q <= araddr_i;
                len_q  <= arlen_i;
                id_q   <= arid_i;
            end
        end
    end

endmodule

`default_nettype wire

// ==== tb.f ====
common/bus_pkg.sv
common/epu_pkg.sv
source/slave_fsm.sv
source/burst_counter.sv
source/buffer_ram.sv
source/reg_map.sv
dot_engine/dot_engine.sv
source/epu_top.sv
bench/epu_assert.sv
bench/tb_epu.sv
